// File: flist.f
+incdir+hdl
hdl/conv_pipe_pkg.sv
hdl/axis_reg_slice.sv
hdl/pixel_shifter.sv
hdl/weight_packer.sv
hdl/beat_joiner.sv
hdl/axis_input_pipe.sv
sim/input_pipe_props.sv
sim/input_pipe_checker.sv
sim/axis_input_pipe_tb.sv

// File: hdl/axis_input_pipe.sv
`timescale 1ns/1ns

module axis_input_pipe (
  input  logic                      aclk,
  input  logic                      arst_n,
  input  conv_pipe_pkg::pix_in_t    s_pix,
  input  logic                      s_pix_valid,
  output logic                      s_pix_ready,
  input  conv_pipe_pkg::wgt_in_t    s_wgt,
  input  logic                      s_wgt_valid,
  output logic                      s_wgt_ready,
  output conv_pipe_pkg::conv_beat_t m_beat,
  output logic                      m_valid,
  input  logic                      m_ready
);

  conv_pipe_pkg::pix_in_t  pix_q;
  logic                    pix_q_valid;
  logic                    pix_q_ready;
  conv_pipe_pkg::wgt_in_t  wgt_q;
  logic                    wgt_q_valid;
  logic                    wgt_q_ready;
  conv_pipe_pkg::pix_row_t row;
  logic                    row_valid;
  logic                    row_ready;
  conv_pipe_pkg::wgt_grp_t grp;
  logic                    grp_valid;
  logic                    grp_ready;

  //////////////////////////////
  // Pixel path
  //////////////////////////////

  axis_reg_slice #(
    .payload_t (conv_pipe_pkg::pix_in_t)
  ) u_pix_slice (
    .aclk    (aclk),
    .arst_n  (arst_n),
    .s_data  (s_pix),
    .s_valid (s_pix_valid),
    .s_ready (s_pix_ready),
    .m_data  (pix_q),
    .m_valid (pix_q_valid),
    .m_ready (pix_q_ready)
  );

  pixel_shifter u_shifter (
    .aclk    (aclk),
    .arst_n  (arst_n),
    .s_pix   (pix_q),
    .s_valid (pix_q_valid),
    .s_ready (pix_q_ready),
    .m_row   (row),
    .m_valid (row_valid),
    .m_ready (row_ready)
  );

  //////////////////////////////
  // Weight path
  //////////////////////////////

  axis_reg_slice #(
    .payload_t (conv_pipe_pkg::wgt_in_t)
  ) u_wgt_slice (
    .aclk    (aclk),
    .arst_n  (arst_n),
    .s_data  (s_wgt),
    .s_valid (s_wgt_valid),
    .s_ready (s_wgt_ready),
    .m_data  (wgt_q),
    .m_valid (wgt_q_valid),
    .m_ready (wgt_q_ready)
  );

  weight_packer u_packer (
    .aclk    (aclk),
    .arst_n  (arst_n),
    .s_wgt   (wgt_q),
    .s_valid (wgt_q_valid),
    .s_ready (wgt_q_ready),
    .m_grp   (grp),
    .m_valid (grp_valid),
    .m_ready (grp_ready)
  );

  beat_joiner u_joiner (
    .row       (row),
    .row_valid (row_valid),
    .row_ready (row_ready),
    .grp       (grp),
    .grp_valid (grp_valid),
    .grp_ready (grp_ready),
    .m_beat    (m_beat),
    .m_valid   (m_valid),
    .m_ready   (m_ready)
  );

endmodule

// File: hdl/axis_reg_slice.sv
`timescale 1ns/1ns

module axis_reg_slice #(
  parameter type payload_t = logic
) (
  input  logic     aclk,
  input  logic     arst_n,
  input  payload_t s_data,
  input  logic     s_valid,
  output logic     s_ready,
  output payload_t m_data,
  output logic     m_valid,
  input  logic     m_ready
);

  payload_t skid_data;
  logic     skid_valid;
  logic     out_free;

  // Ready comes straight from a flop.
  assign s_ready  = !skid_valid;
  assign out_free = m_ready || !m_valid;

  //////////////////////////////
  // Control
  //////////////////////////////

  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      m_valid    <= 1'b0;
      skid_valid <= 1'b0;
    end else begin
      if (out_free) begin
        if (skid_valid) begin
          m_valid    <= 1'b1;     // Drain skid first.
          skid_valid <= 1'b0;
        end else begin
          m_valid <= s_valid;
        end
      end else if (s_valid && !skid_valid) begin
        skid_valid <= 1'b1;       // Output stalled, park the beat.
      end
    end
  end

  //////////////////////////////
  // Data
  //////////////////////////////

  always_ff @(posedge aclk) begin
    if (out_free) begin
      m_data <= skid_valid ? skid_data : s_data;
    end
    if (!skid_valid) begin
      skid_data <= s_data;
    end
  end

endmodule

// File: hdl/beat_joiner.sv
`timescale 1ns/1ns

module beat_joiner (
  input  conv_pipe_pkg::pix_row_t   row,
  input  logic                      row_valid,
  output logic                      row_ready,
  input  conv_pipe_pkg::wgt_grp_t   grp,
  input  logic                      grp_valid,
  output logic                      grp_ready,
  output conv_pipe_pkg::conv_beat_t m_beat,
  output logic                      m_valid,
  input  logic                      m_ready
);

  conv_pipe_pkg::conv_user_t user;
  logic                      both_valid;

  //////////////////////////////
  // Handshake
  //////////////////////////////

  assign both_valid = row_valid && grp_valid;
  assign m_valid    = both_valid;
  assign row_ready  = both_valid && m_ready;    // Both sides move together.
  assign grp_ready  = both_valid && m_ready;

  //////////////////////////////
  // User field
  //////////////////////////////

  always_comb begin
    user.is_max      = row.is_max;
    user.is_lrelu    = row.is_lrelu;
    user.is_1x1      = (row.kernel_h_1 == '0) && (grp.kernel_w_1 == '0);
    user.is_acc_last = row.is_acc_last;
    user.kernel_h_1  = row.kernel_h_1;
    user.kernel_w_1  = grp.kernel_w_1;
  end

  always_comb begin
    m_beat.pixels  = row.data;
    m_beat.weights = grp.data;
    m_beat.user    = user;
    m_beat.last    = row.last;      // Packet end follows pixels.
  end

endmodule

// File: hdl/conv_pipe_consts.svh
`ifndef CONV_PIPE_CONSTS_SVH
`define CONV_PIPE_CONSTS_SVH

//////////////////////////////
// Array sizes
//////////////////////////////

`define UNITS          3    // Pixel rows per beat.
`define CORES          4    // Output channels per beat.
`define WORD_WIDTH     8
`define KERNEL_H_MAX   3
`define KERNEL_W_MAX   3

//////////////////////////////
// Stream sizes
//////////////////////////////

`define IM_IN_WORDS    8    // UNITS + 2 edge rows, padded.
`define WGT_DMA_WORDS  4

`define BITS_KERNEL_H  $clog2(`KERNEL_H_MAX)
`define BITS_KERNEL_W  $clog2(`KERNEL_W_MAX)
`define WGT_GRP_WORDS  (`CORES * `KERNEL_W_MAX)
`define WGT_GRP_BEATS  (`WGT_GRP_WORDS / `WGT_DMA_WORDS)

`endif

// File: hdl/conv_pipe_pkg.sv
`include "conv_pipe_consts.svh"

package conv_pipe_pkg;

  typedef logic [`WORD_WIDTH-1:0] word_t;

  //////////////////////////////
  // Input streams
  //////////////////////////////

  typedef struct packed {
    word_t [`IM_IN_WORDS-1:0] data;
    logic                     last;
  } pix_in_t;

  typedef struct packed {
    word_t [`WGT_DMA_WORDS-1:0] data;
    logic                       last;
  } wgt_in_t;

  // Word 0 of the pixel header beat.
  typedef struct packed {
    logic [3:0]                rsvd;
    logic                      is_max;
    logic                      is_lrelu;
    logic [`BITS_KERNEL_H-1:0] kernel_h_1;
  } pix_hdr_t;

  // Word 0 of the weight config beat.
  typedef struct packed {
    logic [5:0]                rsvd;
    logic [`BITS_KERNEL_W-1:0] kernel_w_1;
  } wgt_cfg_t;

  //////////////////////////////
  // Internal and output streams
  //////////////////////////////

  typedef struct packed {
    word_t [`UNITS-1:0]        data;
    logic                      is_max;
    logic                      is_lrelu;
    logic [`BITS_KERNEL_H-1:0] kernel_h_1;
    logic                      is_acc_last;
    logic                      last;
  } pix_row_t;

  typedef struct packed {
    word_t [`WGT_GRP_WORDS-1:0] data;
    logic [`BITS_KERNEL_W-1:0]  kernel_w_1;
    logic                       last;
  } wgt_grp_t;

  typedef struct packed {
    logic                      is_max;
    logic                      is_lrelu;
    logic                      is_1x1;
    logic                      is_acc_last;
    logic [`BITS_KERNEL_H-1:0] kernel_h_1;
    logic [`BITS_KERNEL_W-1:0] kernel_w_1;
  } conv_user_t;

  typedef struct packed {
    word_t [`UNITS-1:0]         pixels;
    word_t [`WGT_GRP_WORDS-1:0] weights;
    conv_user_t                 user;
    logic                       last;
  } conv_beat_t;

endpackage

// File: hdl/pixel_shifter.sv
`timescale 1ns/1ns
`include "conv_pipe_consts.svh"

module pixel_shifter (
  input  logic                    aclk,
  input  logic                    arst_n,
  input  conv_pipe_pkg::pix_in_t  s_pix,
  input  logic                    s_valid,
  output logic                    s_ready,
  output conv_pipe_pkg::pix_row_t m_row,
  output logic                    m_valid,
  input  logic                    m_ready
);

  conv_pipe_pkg::pix_hdr_t                 hdr_in;
  conv_pipe_pkg::word_t [`IM_IN_WORDS-1:0] beat_data;
  logic                                    beat_last;
  logic                                    in_data;     // Header already taken.
  logic                                    is_max;
  logic                                    is_lrelu;
  logic [`BITS_KERNEL_H-1:0]               kernel_h_1;
  logic [`BITS_KERNEL_H-1:0]               row;
  logic [`BITS_KERNEL_H-1:0]               offset;
  logic                                    final_row;
  logic                                    row_done;
  logic                                    s_fire;

  assign hdr_in    = s_pix.data[0];
  assign final_row = (row == kernel_h_1);
  assign row_done  = m_valid && m_ready && final_row;
  assign s_ready   = !m_valid || row_done;     // Next beat joins the last row.
  assign s_fire    = s_valid && s_ready;

  // 1x1 kernels take the center row.
  assign offset = (kernel_h_1 == '0) ? row + 1'b1 : row;

  //////////////////////////////
  // Header and row control
  //////////////////////////////

  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      in_data    <= 1'b0;
      m_valid    <= 1'b0;
      row        <= '0;
      is_max     <= 1'b0;
      is_lrelu   <= 1'b0;
      kernel_h_1 <= '0;
    end else begin
      if (s_fire && !in_data) begin
        is_max     <= hdr_in.is_max;
        is_lrelu   <= hdr_in.is_lrelu;
        kernel_h_1 <= hdr_in.kernel_h_1;
        in_data    <= 1'b1;
      end
      if (s_fire && in_data) begin
        m_valid <= 1'b1;
        row     <= '0;
        if (s_pix.last) begin
          in_data <= 1'b0;        // Back to header.
        end
      end else if (row_done) begin
        m_valid <= 1'b0;
        row     <= '0;
      end else if (m_valid && m_ready) begin
        row <= row + 1'b1;
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (s_fire && in_data) begin
      beat_data <= s_pix.data;
      beat_last <= s_pix.last;
    end
  end

  //////////////////////////////
  // Row window
  //////////////////////////////

  always_comb begin
    for (int i = 0; i < `UNITS; i++) begin
      m_row.data[i] = beat_data[int'(offset) + i];
    end
    m_row.is_max      = is_max;
    m_row.is_lrelu    = is_lrelu;
    m_row.kernel_h_1  = kernel_h_1;
    m_row.is_acc_last = final_row;
    m_row.last        = beat_last && final_row;
  end

endmodule

// File: hdl/weight_packer.sv
`timescale 1ns/1ns
`include "conv_pipe_consts.svh"

module weight_packer (
  input  logic                    aclk,
  input  logic                    arst_n,
  input  conv_pipe_pkg::wgt_in_t  s_wgt,
  input  logic                    s_valid,
  output logic                    s_ready,
  output conv_pipe_pkg::wgt_grp_t m_grp,
  output logic                    m_valid,
  input  logic                    m_ready
);

  localparam logic [1:0] LAST_BEAT = 2'(`WGT_GRP_BEATS - 1);

  conv_pipe_pkg::wgt_cfg_t                   cfg_in;
  conv_pipe_pkg::word_t [`WGT_GRP_WORDS-1:0] grp_data;
  logic                                      grp_last;
  logic                                      in_data;   // Config already taken.
  logic [`BITS_KERNEL_W-1:0]                 kernel_w_1;
  logic [1:0]                                cnt;
  logic                                      grp_end;
  logic                                      s_fire;
  logic                                      d_fire;

  assign cfg_in  = s_wgt.data[0];
  assign grp_end = (cnt == LAST_BEAT);
  assign s_ready = !m_valid || m_ready;   // Group register free or leaving.
  assign s_fire  = s_valid && s_ready;
  assign d_fire  = s_fire && in_data;

  //////////////////////////////
  // Control
  //////////////////////////////

  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      in_data    <= 1'b0;
      kernel_w_1 <= '0;
      cnt        <= '0;
      m_valid    <= 1'b0;
    end else begin
      if (s_fire && !in_data) begin
        kernel_w_1 <= cfg_in.kernel_w_1;
        in_data    <= 1'b1;
      end
      if (d_fire) begin
        cnt <= grp_end ? '0 : cnt + 1'b1;
        if (grp_end && s_wgt.last) begin
          in_data <= 1'b0;        // Wait for next config.
        end
      end
      if (d_fire && grp_end) begin
        m_valid <= 1'b1;
      end else if (m_ready) begin
        m_valid <= 1'b0;
      end
    end
  end

  //////////////////////////////
  // Packing
  //////////////////////////////

  always_ff @(posedge aclk) begin
    if (d_fire) begin
      for (int j = 0; j < `WGT_DMA_WORDS; j++) begin
        grp_data[`WGT_DMA_WORDS * int'(cnt) + j] <= s_wgt.data[j];
      end
      if (grp_end) begin
        grp_last <= s_wgt.last;
      end
    end
  end

  assign m_grp.data       = grp_data;
  assign m_grp.kernel_w_1 = kernel_w_1;
  assign m_grp.last       = grp_last;

endmodule

// File: run_sim.sh
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -f flist.f \
  --top-module axis_input_pipe_tb -o axis_input_pipe_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/axis_input_pipe_sim +verilator+error+limit+1000 > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Verification failed" "$log"; then
  exit 1
fi
exit 0

// File: sim/axis_input_pipe_tb.sv
`timescale 1ns/1ns

module axis_input_pipe_tb;

  localparam int unsigned N_PKTS      = 40;
  localparam int unsigned CLK_NS      = 4;
  localparam int unsigned GRP_BEATS   = 3;
  localparam int unsigned WATCHDOG_NS = N_PKTS * 40 * CLK_NS * 4;

  logic                      aclk;
  logic                      arst_n;
  conv_pipe_pkg::pix_in_t    s_pix;
  logic                      s_pix_valid;
  logic                      s_pix_ready;
  conv_pipe_pkg::wgt_in_t    s_wgt;
  logic                      s_wgt_valid;
  logic                      s_wgt_ready;
  conv_pipe_pkg::conv_beat_t m_beat;
  logic                      m_valid;
  logic                      m_ready;
  int unsigned               chk_errors;
  int unsigned               chk_beats;
  int unsigned               chk_pending;
  int unsigned               tb_errors;
  int unsigned               total_beats;
  conv_pipe_pkg::pix_in_t    pix_beats[$];
  conv_pipe_pkg::wgt_in_t    wgt_beats[$];

  axis_input_pipe i_dut (.*);

  input_pipe_checker u_checker (
    .errors  (chk_errors),
    .beats   (chk_beats),
    .pending (chk_pending),
    .*
  );

  initial aclk = 1'b0;
  always #(CLK_NS / 2) aclk = ~aclk;

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  task automatic build_packets();
    conv_pipe_pkg::pix_in_t pb;
    conv_pipe_pkg::wgt_in_t wb;
    logic [1:0]             k1;
    logic [1:0]             kw1;
    int unsigned            m;
    int unsigned            n_grp;
    for (int p = 0; p < int'(N_PKTS); p++) begin
      k1    = ($urandom_range(0, 1) == 1) ? 2'd2 : 2'd0;   // 3x3 or 1x1.
      kw1   = ($urandom_range(0, 1) == 1) ? 2'd2 : 2'd0;
      m     = $urandom_range(1, 4);
      n_grp = m * (k1 + 1);
      pb         = {$urandom, $urandom, 1'b0};
      pb.data[0] = {4'($urandom), 1'($urandom), 1'($urandom), k1};
      pix_beats.push_back(pb);
      for (int b = 0; b < int'(m); b++) begin
        pb      = {$urandom, $urandom, 1'b0};
        pb.last = (b == int'(m) - 1);
        pix_beats.push_back(pb);
      end
      wb         = {$urandom, 1'b0};
      wb.data[0] = {6'($urandom), kw1};
      wgt_beats.push_back(wb);
      for (int b = 0; b < int'(n_grp * GRP_BEATS); b++) begin
        wb      = {$urandom, 1'b0};
        wb.last = (b == int'(n_grp * GRP_BEATS) - 1);
        wgt_beats.push_back(wb);
      end
      total_beats += n_grp;
    end
  endtask

  task automatic drive_pixels();
    logic taken;
    while (pix_beats.size() > 0) begin
      while ($urandom_range(0, 3) == 0) begin
        s_pix_valid = 1'b0;
        @(posedge aclk);
        #1;
      end
      s_pix       = pix_beats.pop_front();
      s_pix_valid = 1'b1;
      do begin
        @(negedge aclk);
        taken = s_pix_ready;          // Ready is a flop, steady until the edge.
        @(posedge aclk);
        #1;
      end while (!taken);
    end
    s_pix_valid = 1'b0;
  endtask

  task automatic drive_weights();
    logic taken;
    while (wgt_beats.size() > 0) begin
      while ($urandom_range(0, 3) == 0) begin
        s_wgt_valid = 1'b0;
        @(posedge aclk);
        #1;
      end
      s_wgt       = wgt_beats.pop_front();
      s_wgt_valid = 1'b1;
      do begin
        @(negedge aclk);
        taken = s_wgt_ready;
        @(posedge aclk);
        #1;
      end while (!taken);
    end
    s_wgt_valid = 1'b0;
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    void'($urandom(32'ha585_142b));
    arst_n      = 1'b0;
    s_pix       = '0;
    s_pix_valid = 1'b0;
    s_wgt       = '0;
    s_wgt_valid = 1'b0;
    m_ready     = 1'b0;
    tb_errors   = 0;
    total_beats = 0;
    build_packets();
    repeat (5) @(posedge aclk);
    #1;
    arst_n = 1'b1;
    repeat (8) begin
      @(negedge aclk);
      if (m_valid !== 1'b0) begin
        tb_errors++;
        $display("CHECK FAILED t=%0t m_valid got=%b exp=0", $time, m_valid);
      end
    end
    @(posedge aclk);
    #1;
    fork
      drive_pixels();
      drive_weights();
    join
    wait (chk_beats >= total_beats);
    repeat (20) @(posedge aclk);
    if (chk_beats != total_beats || chk_pending != 0) begin
      tb_errors++;
      $display("Beat count mismatch: %0d of %0d beats seen, %0d expected entries left",
               chk_beats, total_beats, chk_pending);
    end
    $display("Summary: beats=%0d/%0d checker_errors=%0d tb_errors=%0d assert_errors=%0d",
             chk_beats, total_beats, chk_errors, tb_errors, i_dut.u_props.fail_count);
    if (chk_errors + tb_errors + i_dut.u_props.fail_count == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  // Random back-pressure at the output.
  initial begin
    @(posedge arst_n);
    forever begin
      @(posedge aclk);
      #1;
      m_ready = ($urandom_range(0, 3) != 0);
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired at %0t with %0d of %0d beats seen",
             $time, chk_beats, total_beats);
    $display("Verification failed");
    $finish;
  end

endmodule

// File: sim/input_pipe_checker.sv
`timescale 1ns/1ns
`include "conv_pipe_consts.svh"

module input_pipe_checker (
  input  logic                      aclk,
  input  logic                      arst_n,
  input  conv_pipe_pkg::pix_in_t    s_pix,
  input  logic                      s_pix_valid,
  input  logic                      s_pix_ready,
  input  conv_pipe_pkg::wgt_in_t    s_wgt,
  input  logic                      s_wgt_valid,
  input  logic                      s_wgt_ready,
  input  conv_pipe_pkg::conv_beat_t m_beat,
  input  logic                      m_valid,
  input  logic                      m_ready,
  output int unsigned               errors,
  output int unsigned               beats,
  output int unsigned               pending
);

  conv_pipe_pkg::pix_row_t                   rows[$];
  conv_pipe_pkg::wgt_grp_t                   grps[$];
  conv_pipe_pkg::pix_hdr_t                   hdr;
  conv_pipe_pkg::word_t [`WGT_GRP_WORDS-1:0] grp_words;
  logic [`BITS_KERNEL_W-1:0]                 kernel_w_1;
  logic                                      pix_body;    // Header seen.
  logic                                      wgt_body;    // Config seen.
  int                                        wgt_cnt;

  task automatic check_field(input string name, input logic [95:0] got,
                             input logic [95:0] exp);
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED t=%0t %s got=%0h exp=%0h", $time, name, got, exp);
    end
  endtask

  //////////////////////////////
  // Reference model
  //////////////////////////////

  task automatic expect_rows();
    conv_pipe_pkg::pix_row_t r;
    int                      off;
    for (int k = 0; k <= int'(hdr.kernel_h_1); k++) begin
      off = (hdr.kernel_h_1 == 0) ? 1 : k;      // Center row for 1x1.
      for (int i = 0; i < `UNITS; i++) begin
        r.data[i] = s_pix.data[off + i];
      end
      r.is_max      = hdr.is_max;
      r.is_lrelu    = hdr.is_lrelu;
      r.kernel_h_1  = hdr.kernel_h_1;
      r.is_acc_last = (k == int'(hdr.kernel_h_1));
      r.last        = s_pix.last && r.is_acc_last;
      rows.push_back(r);
    end
  endtask

  task automatic collect_weights();
    conv_pipe_pkg::wgt_grp_t g;
    for (int j = 0; j < `WGT_DMA_WORDS; j++) begin
      grp_words[`WGT_DMA_WORDS * wgt_cnt + j] = s_wgt.data[j];
    end
    wgt_cnt++;
    if (wgt_cnt == `WGT_GRP_BEATS) begin
      g.data       = grp_words;
      g.kernel_w_1 = kernel_w_1;
      g.last       = s_wgt.last;
      grps.push_back(g);
      wgt_cnt  = 0;
      wgt_body = !s_wgt.last;
    end
  endtask

  task automatic compare_beat();
    conv_pipe_pkg::pix_row_t r;
    conv_pipe_pkg::wgt_grp_t g;
    r = rows.pop_front();
    g = grps.pop_front();
    check_field("m_beat.pixels", 96'(m_beat.pixels), 96'(r.data));
    check_field("m_beat.weights", m_beat.weights, g.data);
    check_field("m_beat.user.is_max", 96'(m_beat.user.is_max), 96'(r.is_max));
    check_field("m_beat.user.is_lrelu", 96'(m_beat.user.is_lrelu), 96'(r.is_lrelu));
    check_field("m_beat.user.is_1x1", 96'(m_beat.user.is_1x1),
                96'(r.kernel_h_1 == 0 && g.kernel_w_1 == 0));
    check_field("m_beat.user.is_acc_last", 96'(m_beat.user.is_acc_last), 96'(r.is_acc_last));
    check_field("m_beat.user.kernel_h_1", 96'(m_beat.user.kernel_h_1), 96'(r.kernel_h_1));
    check_field("m_beat.user.kernel_w_1", 96'(m_beat.user.kernel_w_1), 96'(g.kernel_w_1));
    check_field("m_beat.last", 96'(m_beat.last), 96'(r.last));
  endtask

  //////////////////////////////
  // Port monitors
  //////////////////////////////

  always @(negedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      errors   = 0;
      beats    = 0;
      pix_body = 1'b0;
      wgt_body = 1'b0;
      wgt_cnt  = 0;
      rows.delete();
      grps.delete();
    end else begin
      if (m_valid && m_ready) begin
        beats++;
        if (rows.size() == 0 || grps.size() == 0) begin
          errors++;
          $display("Output beat at %0t arrived with nothing expected", $time);
        end else begin
          compare_beat();
        end
      end
      if (s_pix_valid && s_pix_ready) begin
        if (!pix_body) begin
          hdr      = s_pix.data[0];
          pix_body = 1'b1;
        end else begin
          expect_rows();
          pix_body = !s_pix.last;
        end
      end
      if (s_wgt_valid && s_wgt_ready) begin
        if (!wgt_body) begin
          kernel_w_1 = s_wgt.data[0][`BITS_KERNEL_W-1:0];
          wgt_body   = 1'b1;
        end else begin
          collect_weights();
        end
      end
    end
    pending = rows.size() + grps.size();
  end

endmodule

// File: sim/input_pipe_props.sv
`timescale 1ns/1ns

module input_pipe_props (
  input logic                      aclk,
  input logic                      arst_n,
  input conv_pipe_pkg::pix_in_t    s_pix,
  input logic                      s_pix_valid,
  input logic                      s_pix_ready,
  input conv_pipe_pkg::wgt_in_t    s_wgt,
  input logic                      s_wgt_valid,
  input logic                      s_wgt_ready,
  input conv_pipe_pkg::conv_beat_t m_beat,
  input logic                      m_valid,
  input logic                      m_ready,
  input conv_pipe_pkg::pix_row_t   row,
  input logic                      row_valid,
  input conv_pipe_pkg::wgt_grp_t   grp,
  input logic                      grp_valid
);

  int unsigned fail_count = 0;

  //////////////////////////////
  // Stream stability
  //////////////////////////////

  pix_hold: assert property (@(posedge aclk) disable iff (!arst_n)
    s_pix_valid && !s_pix_ready |=> s_pix_valid && $stable(s_pix))
  else begin
    fail_count++;
    $error("Pixel input changed while stalled.");
  end

  wgt_hold: assert property (@(posedge aclk) disable iff (!arst_n)
    s_wgt_valid && !s_wgt_ready |=> s_wgt_valid && $stable(s_wgt))
  else begin
    fail_count++;
    $error("Weight input changed while stalled.");
  end

  out_hold: assert property (@(posedge aclk) disable iff (!arst_n)
    m_valid && !m_ready |=> m_valid && $stable(m_beat))
  else begin
    fail_count++;
    $error("Output beat changed while stalled.");
  end

  //////////////////////////////
  // Reset and alignment
  //////////////////////////////

  quiet_in_reset: assert property (@(posedge aclk) !arst_n |-> !m_valid)
  else begin
    fail_count++;
    $error("Output valid during reset.");
  end

  last_aligned: assert property (@(posedge aclk) disable iff (!arst_n)
    row_valid && grp_valid |-> row.last == grp.last)
  else begin
    fail_count++;
    $error("Pixel row and weight group disagree on packet end.");
  end

endmodule

bind axis_input_pipe input_pipe_props u_props (
  .aclk        (aclk),
  .arst_n      (arst_n),
  .s_pix       (s_pix),
  .s_pix_valid (s_pix_valid),
  .s_pix_ready (s_pix_ready),
  .s_wgt       (s_wgt),
  .s_wgt_valid (s_wgt_valid),
  .s_wgt_ready (s_wgt_ready),
  .m_beat      (m_beat),
  .m_valid     (m_valid),
  .m_ready     (m_ready),
  .row         (row),
  .row_valid   (row_valid),
  .grp         (grp),
  .grp_valid   (grp_valid)
);
